//--- cl_hello_top.f
+incdir+testbench
source/cl_hello_pkg.sv
source/axil_skid_buf.sv
source/axil_slave_ctrl.sv
source/hello_regs.sv
source/cl_hello_top.sv
testbench/tb_cl_hello_top.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the cl_hello_top testbench with Verilator
# Exit status 0 only when the log holds the pass message

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir
BIN=sim_cl_hello

verilator --binary --timing --assert \
  --top-module tb_cl_hello_top \
  -f cl_hello_top.f \
  --Mdir "$OBJ" -o "$BIN"
if [ $? -ne 0 ]; then
  echo "Build failed"
  exit 1
fi

"./$OBJ/$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulator exited with status $status"
  exit 1
fi

if grep -q "^Simulation PASSED$" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1

//--- source/axil_skid_buf.sv
//--------------------------------------------------------------------------
// Two-entry valid/ready buffer for a single AXI-Lite channel
// in_ready and out_valid are both flops, so no combinational path crosses
// Payload storage has no reset, only pointers and flags are cleared
//--------------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module axil_skid_buf #(
  parameter int WIDTH = 32
) (
  input  logic             clk_main_a0,
  input  logic             rst_main_n_sync,
  // Upstream side
  input  logic             in_valid,
  output logic             in_ready,
  input  logic [WIDTH-1:0] in_data,
  // Downstream side
  output logic             out_valid,
  input  logic             out_ready,
  output logic [WIDTH-1:0] out_data
);

  // Storage, two slots
  logic [WIDTH-1:0] mem [2];
  logic             wr_ptr;
  logic             rd_ptr;
  // Occupancy 0..2
  logic [1:0]       count;
  logic [1:0]       count_nxt;
  logic             push;
  logic             pop;

  assign push = in_valid && in_ready;
  assign pop  = out_valid && out_ready;

  // Next occupancy
  always_comb begin
    count_nxt = count;
    case ({push, pop})
      2'b10:   count_nxt = count + 2'd1;
      2'b01:   count_nxt = count - 2'd1;
      // Push and pop together leave it unchanged
      default: count_nxt = count;
    endcase
  end

  //------------------------------------------------------------------------
  // Control flops
  //------------------------------------------------------------------------
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      count     <= 2'd0;
      wr_ptr    <= 1'b0;
      rd_ptr    <= 1'b0;
      in_ready  <= 1'b1;
      out_valid <= 1'b0;
    end else begin
      count <= count_nxt;
      if (push) begin
        wr_ptr <= ~wr_ptr;
      end
      if (pop) begin
        rd_ptr <= ~rd_ptr;
      end
      // Ready is "not full" one cycle ahead
      in_ready  <= (count_nxt != 2'd2);
      out_valid <= (count_nxt != 2'd0);
    end
  end

  // Payload write
  always_ff @(posedge clk_main_a0) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
  end

  // Head of buffer
  assign out_data = mem[rd_ptr];

  // Held item must not change or vanish while stalled
  a_out_stable : assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule

`default_nettype wire

//--- source/axil_slave_ctrl.sv
//--------------------------------------------------------------------------
// AXI-Lite target protocol FSMs with independent write and read paths
// One outstanding access per path and no IDs, bursts or error responses
// Address decode is left to the register block
//--------------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module axil_slave_ctrl (
  input  logic                   clk_main_a0,
  input  logic                   rst_main_n_sync,
  // Write address
  input  logic                   aw_valid,
  input  cl_hello_pkg::axil_aw_t aw,
  output logic                   aw_ready,
  // Write data
  input  logic                   w_valid,
  input  cl_hello_pkg::axil_w_t  w,
  output logic                   w_ready,
  // Write response
  output logic                   b_valid,
  output cl_hello_pkg::axil_b_t  b,
  input  logic                   b_ready,
  // Read address
  input  logic                   ar_valid,
  input  cl_hello_pkg::axil_ar_t ar,
  output logic                   ar_ready,
  // Read data
  output logic                   r_valid,
  output cl_hello_pkg::axil_r_t  r,
  input  logic                   r_ready,
  // Register block side
  output cl_hello_pkg::reg_wr_t  reg_wr,
  output cl_hello_pkg::reg_rd_t  reg_rd,
  input  cl_hello_pkg::reg_word_t rd_data
);

  import cl_hello_pkg::*;

  wr_state_e wr_state;
  wr_state_e wr_state_nxt;
  rd_state_e rd_state;
  rd_state_e rd_state_nxt;
  reg_addr_t wr_addr_q;
  reg_addr_t rd_addr_q;

  //------------------------------------------------------------------------
  // Write path
  //------------------------------------------------------------------------
  assign aw_ready = (wr_state == WR_IDLE);
  // Ready follows valid once the address is held
  assign w_ready  = (wr_state == WR_DATA) && w_valid;
  assign b_valid  = (wr_state == WR_RESP);
  assign b.resp   = RESP_OKAY;

  always_comb begin
    wr_state_nxt = wr_state;
    case (wr_state)
      WR_IDLE: if (aw_valid) wr_state_nxt = WR_DATA;
      WR_DATA: if (w_valid) wr_state_nxt = WR_RESP;
      WR_RESP: if (b_ready) wr_state_nxt = WR_IDLE;
      default: wr_state_nxt = WR_IDLE;
    endcase
  end

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      wr_state <= WR_IDLE;
    end else begin
      wr_state <= wr_state_nxt;
    end
  end

  // Address captured on the aw handshake
  always_ff @(posedge clk_main_a0) begin
    if (aw_valid && aw_ready) begin
      wr_addr_q <= aw.addr;
    end
  end

  // Write strobe lasts exactly the w transfer cycle
  // Strobe bits are dropped and only full words are written
  always_comb begin
    reg_wr.en   = w_valid && w_ready;
    reg_wr.addr = wr_addr_q;
    reg_wr.data = w.data;
  end

  //------------------------------------------------------------------------
  // Read path
  //------------------------------------------------------------------------
  assign ar_ready = (rd_state == RD_IDLE);
  assign r_valid  = (rd_state == RD_RESP);

  always_comb begin
    rd_state_nxt = rd_state;
    case (rd_state)
      RD_IDLE:   if (ar_valid) rd_state_nxt = RD_LOOKUP;
      // Single lookup cycle
      RD_LOOKUP: rd_state_nxt = RD_RESP;
      RD_RESP:   if (r_ready) rd_state_nxt = RD_IDLE;
      default:   rd_state_nxt = RD_IDLE;
    endcase
  end

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      rd_state <= RD_IDLE;
    end else begin
      rd_state <= rd_state_nxt;
    end
  end

  always_ff @(posedge clk_main_a0) begin
    if (ar_valid && ar_ready) begin
      rd_addr_q <= ar.addr;
    end
  end

  // Lookup request to the register block
  always_comb begin
    reg_rd.en   = (rd_state == RD_LOOKUP);
    reg_rd.addr = rd_addr_q;
  end

  // Response payload held until r_ready
  always_ff @(posedge clk_main_a0) begin
    if (rd_state == RD_LOOKUP) begin
      r.data <= rd_data;
      r.resp <= RESP_OKAY;
    end
  end

  //------------------------------------------------------------------------
  // Checks
  //------------------------------------------------------------------------
  // Write data parked ahead of its address must stay put until taken
  a_w_hold : assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    w_valid && !w_ready |=> w_valid && $stable(w));

  // Same for an address that arrives while a write is still open
  a_aw_hold : assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    aw_valid && !aw_ready |=> aw_valid && $stable(aw));

endmodule

`default_nettype wire

//--- source/cl_hello_pkg.sv
//--------------------------------------------------------------------------
// Shared types for the hello-world AXI-Lite register block
// Register map is word aligned and byte addressed, single beat only
// Only full-word writes are meaningful, the strobe is carried but ignored
//--------------------------------------------------------------------------
`default_nettype none

package cl_hello_pkg;

  //------------------------------------------------------------------------
  // Basic register types
  //------------------------------------------------------------------------
  typedef logic [31:0] reg_addr_t;
  typedef logic [31:0] reg_word_t;
  // Virtual LED / DIP vector, half a word
  typedef logic [15:0] vled_t;

  // AXI response codes
  // Only OKAY is produced by the design
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } axi_resp_e;

  //------------------------------------------------------------------------
  // AXI-Lite channel payloads
  //------------------------------------------------------------------------
  typedef struct packed {
    reg_addr_t addr;
  } axil_aw_t;

  typedef struct packed {
    reg_addr_t addr;
  } axil_ar_t;

  // Write data with byte strobes, 36 bits
  typedef struct packed {
    reg_word_t  data;
    logic [3:0] strb;
  } axil_w_t;

  typedef struct packed {
    axi_resp_e resp;
  } axil_b_t;

  // Read data plus response, 34 bits
  typedef struct packed {
    reg_word_t data;
    axi_resp_e resp;
  } axil_r_t;

  //------------------------------------------------------------------------
  // Controller to register block
  //------------------------------------------------------------------------
  // Single-cycle write strobe
  typedef struct packed {
    logic      en;
    reg_addr_t addr;
    reg_word_t data;
  } reg_wr_t;

  // Read lookup request, data returns combinationally
  typedef struct packed {
    logic      en;
    reg_addr_t addr;
  } reg_rd_t;

  // FSM states
  typedef enum logic [1:0] {WR_IDLE, WR_DATA, WR_RESP} wr_state_e;
  typedef enum logic [1:0] {RD_IDLE, RD_LOOKUP, RD_RESP} rd_state_e;

  //------------------------------------------------------------------------
  // Register map
  //------------------------------------------------------------------------
  localparam reg_addr_t HELLO_ADDR   = 32'h0000_0500;
  localparam reg_addr_t VLED_ADDR    = 32'h0000_0504;
  localparam reg_addr_t VERSION_ADDR = 32'h0000_0508;

  // Returned for any unmapped read
  localparam reg_word_t UNMAPPED_VALUE = 32'hDEAD_BEEF;

endpackage

`default_nettype wire

//--- source/cl_hello_top.sv
//--------------------------------------------------------------------------
// Hello-world custom logic top, AXI-Lite target with timing buffers
// Reset must already be synchronous to clk_main_a0
// About 4 cycles from request to response without back-pressure
//--------------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module cl_hello_top #(
  parameter cl_hello_pkg::reg_word_t CL_VERSION = 32'hEEEE_EE00
) (
  input  logic                   clk_main_a0,
  input  logic                   rst_main_n_sync,
  // Host AXI-Lite
  input  logic                   aw_valid,
  input  cl_hello_pkg::axil_aw_t aw,
  output logic                   aw_ready,
  input  logic                   w_valid,
  input  cl_hello_pkg::axil_w_t  w,
  output logic                   w_ready,
  output logic                   b_valid,
  output cl_hello_pkg::axil_b_t  b,
  input  logic                   b_ready,
  input  logic                   ar_valid,
  input  cl_hello_pkg::axil_ar_t ar,
  output logic                   ar_ready,
  output logic                   r_valid,
  output cl_hello_pkg::axil_r_t  r,
  input  logic                   r_ready,
  // Virtual DIP in, virtual LED out
  input  cl_hello_pkg::vled_t    vdip,
  output cl_hello_pkg::vled_t    vled
);

  import cl_hello_pkg::*;

  //------------------------------------------------------------------------
  // Controller side of the buffers
  //------------------------------------------------------------------------
  logic      c_aw_valid, c_aw_ready;
  axil_aw_t  c_aw;
  logic      c_w_valid, c_w_ready;
  axil_w_t   c_w;
  logic      c_b_valid, c_b_ready;
  axil_b_t   c_b;
  logic      c_ar_valid, c_ar_ready;
  axil_ar_t  c_ar;
  logic      c_r_valid, c_r_ready;
  axil_r_t   c_r;
  // Register interface
  reg_wr_t   reg_wr;
  reg_rd_t   reg_rd;
  reg_word_t rd_data;

  // Host to controller
  axil_skid_buf #(.WIDTH($bits(axil_aw_t))) u_aw_buf (
    .clk_main_a0, .rst_main_n_sync,
    .in_valid  (aw_valid),   .in_ready  (aw_ready),   .in_data  (aw),
    .out_valid (c_aw_valid), .out_ready (c_aw_ready), .out_data (c_aw)
  );

  axil_skid_buf #(.WIDTH($bits(axil_w_t))) u_w_buf (
    .clk_main_a0, .rst_main_n_sync,
    .in_valid  (w_valid),   .in_ready  (w_ready),   .in_data  (w),
    .out_valid (c_w_valid), .out_ready (c_w_ready), .out_data (c_w)
  );

  axil_skid_buf #(.WIDTH($bits(axil_ar_t))) u_ar_buf (
    .clk_main_a0, .rst_main_n_sync,
    .in_valid  (ar_valid),   .in_ready  (ar_ready),   .in_data  (ar),
    .out_valid (c_ar_valid), .out_ready (c_ar_ready), .out_data (c_ar)
  );

  // Controller to host
  axil_skid_buf #(.WIDTH($bits(axil_b_t))) u_b_buf (
    .clk_main_a0, .rst_main_n_sync,
    .in_valid  (c_b_valid), .in_ready  (c_b_ready), .in_data  (c_b),
    .out_valid (b_valid),   .out_ready (b_ready),   .out_data (b)
  );

  axil_skid_buf #(.WIDTH($bits(axil_r_t))) u_r_buf (
    .clk_main_a0, .rst_main_n_sync,
    .in_valid  (c_r_valid), .in_ready  (c_r_ready), .in_data  (c_r),
    .out_valid (r_valid),   .out_ready (r_ready),   .out_data (r)
  );

  //------------------------------------------------------------------------
  // Protocol FSMs and registers
  //------------------------------------------------------------------------
  axil_slave_ctrl u_ctrl (
    .clk_main_a0, .rst_main_n_sync,
    .aw_valid (c_aw_valid), .aw (c_aw), .aw_ready (c_aw_ready),
    .w_valid  (c_w_valid),  .w  (c_w),  .w_ready  (c_w_ready),
    .b_valid  (c_b_valid),  .b  (c_b),  .b_ready  (c_b_ready),
    .ar_valid (c_ar_valid), .ar (c_ar), .ar_ready (c_ar_ready),
    .r_valid  (c_r_valid),  .r  (c_r),  .r_ready  (c_r_ready),
    .reg_wr, .reg_rd, .rd_data
  );

  hello_regs #(.CL_VERSION(CL_VERSION)) u_regs (
    .clk_main_a0, .rst_main_n_sync,
    .reg_wr, .reg_rd, .rd_data,
    .vdip, .vled
  );

endmodule

`default_nettype wire

//--- source/hello_regs.sv
//--------------------------------------------------------------------------
// Hello-world register block with LED shadow and version word
// Writes to anything but the hello-world word are dropped silently
// rd_data is combinational and only meaningful while reg_rd.en is high
//--------------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module hello_regs #(
  parameter cl_hello_pkg::reg_word_t CL_VERSION = 32'hEEEE_EE00
) (
  input  logic                    clk_main_a0,
  input  logic                    rst_main_n_sync,
  // From controller
  input  cl_hello_pkg::reg_wr_t   reg_wr,
  input  cl_hello_pkg::reg_rd_t   reg_rd,
  output cl_hello_pkg::reg_word_t rd_data,
  // Virtual switches and LEDs
  input  cl_hello_pkg::vled_t     vdip,
  output cl_hello_pkg::vled_t     vled
);

  import cl_hello_pkg::*;

  reg_word_t hello_q;
  reg_word_t hello_swapped;
  vled_t     vled_q;
  logic      hello_wr;

  //------------------------------------------------------------------------
  // Hello-world word
  //------------------------------------------------------------------------
  assign hello_wr = reg_wr.en && (reg_wr.addr == HELLO_ADDR);

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      hello_q <= '0;
    end else if (hello_wr) begin
      hello_q <= reg_wr.data;
    end
  end

  // Reads back with byte order reversed
  assign hello_swapped = {hello_q[7:0], hello_q[15:8], hello_q[23:16], hello_q[31:24]};

  //------------------------------------------------------------------------
  // Virtual LEDs
  //------------------------------------------------------------------------
  // Shadow of the low half, one cycle behind
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      vled_q <= '0;
    end else begin
      vled_q <= hello_q[15:0];
    end
  end

  // DIP switches mask what reaches the LEDs
  assign vled = vled_q & vdip;

  //------------------------------------------------------------------------
  // Read mux
  //------------------------------------------------------------------------
  always_comb begin
    rd_data = '0;
    if (reg_rd.en) begin
      case (reg_rd.addr)
        HELLO_ADDR:   rd_data = hello_swapped;
        // LED value, zero extended
        VLED_ADDR:    rd_data = {16'h0000, vled_q};
        VERSION_ADDR: rd_data = CL_VERSION;
        default:      rd_data = UNMAPPED_VALUE;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- testbench/tb_axil_tasks.svh
//--------------------------------------------------------------------------
// Host-side AXI-Lite tasks, compare tasks and random source for the testbench
// Included inside the testbench module, uses its signals and error counters
// Every task starts and ends on a falling clock edge
//--------------------------------------------------------------------------
`ifndef TB_AXIL_TASKS_SVH
`define TB_AXIL_TASKS_SVH

  // Channel ids for the bounded waits
  localparam int CH_AW = 0;
  localparam int CH_W  = 1;
  localparam int CH_AR = 2;
  localparam int CH_B  = 3;
  localparam int CH_R  = 4;

  string flag_names [5] = '{"aw_ready", "w_ready", "ar_ready", "b_valid", "r_valid"};

  //------------------------------------------------------------------------
  // Random source
  //------------------------------------------------------------------------
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  //------------------------------------------------------------------------
  // Handshake helpers
  //------------------------------------------------------------------------
  function automatic logic flag_now(input int ch);
    case (ch)
      CH_AW:   return aw_ready;
      CH_W:    return w_ready;
      CH_AR:   return ar_ready;
      CH_B:    return b_valid;
      default: return r_valid;
    endcase
  endfunction

  // Response beat in r layout, b carries no data
  function automatic axil_r_t beat_now(input int ch);
    axil_r_t beat;
    beat = r;
    if (ch == CH_B) begin
      beat.data = '0;
      beat.resp = b.resp;
    end
    return beat;
  endfunction

  // Ready and valid are flops, so the falling-edge value holds at the next edge
  task automatic await_flag(input int ch, output logic ok);
    int n;
    n = 0;
    while (!flag_now(ch) && n < HS_LIMIT) begin
      @(negedge clk_main_a0);
      n++;
    end
    ok = flag_now(ch);
    if (!ok) begin
      $display("Timeout in %s: %s never went high within %0d cycles",
               test_name, flag_names[ch], HS_LIMIT);
      proto_errs++;
    end
  endtask

  // Wait for a response, stall it for hold cycles, then accept it
  task automatic collect_resp(input int ch, input int hold, output axil_r_t beat);
    logic    ok;
    axil_r_t first;
    await_flag(ch, ok);
    beat = beat_now(ch);
    if (!ok) return;
    first = beat;
    repeat (hold) begin
      @(negedge clk_main_a0);
      if (!flag_now(ch) || beat_now(ch) !== first) begin
        $display("Error in %s: %s response dropped or changed while stalled",
                 test_name, (ch == CH_B) ? "write" : "read");
        proto_errs++;
      end
    end
    if (ch == CH_B) b_ready = 1'b1;
    else r_ready = 1'b1;
    @(negedge clk_main_a0);
    b_ready = 1'b0;
    r_ready = 1'b0;
  endtask

  //------------------------------------------------------------------------
  // Bus transactions
  //------------------------------------------------------------------------
  // w goes out w_lead cycles ahead of aw
  task automatic axil_write(input reg_addr_t addr, input reg_word_t data,
                            input int w_lead, input int b_hold, output axi_resp_e resp);
    logic    ok_aw;
    logic    ok_w;
    axil_r_t beat;
    fork
      begin
        repeat (w_lead) @(negedge clk_main_a0);
        aw_valid = 1'b1;
        aw.addr  = addr;
        await_flag(CH_AW, ok_aw);
        @(negedge clk_main_a0);
        aw_valid = 1'b0;
      end
      begin
        w_valid = 1'b1;
        w.data  = data;
        w.strb  = 4'hF;
        await_flag(CH_W, ok_w);
        @(negedge clk_main_a0);
        w_valid = 1'b0;
      end
    join
    collect_resp(CH_B, b_hold, beat);
    resp = beat.resp;
  endtask

  task automatic axil_read(input reg_addr_t addr, input int r_hold,
                           output reg_word_t data, output axi_resp_e resp);
    logic    ok;
    axil_r_t beat;
    ar_valid = 1'b1;
    ar.addr  = addr;
    await_flag(CH_AR, ok);
    @(negedge clk_main_a0);
    ar_valid = 1'b0;
    collect_resp(CH_R, r_hold, beat);
    data = beat.data;
    resp = beat.resp;
  endtask

  //------------------------------------------------------------------------
  // Compare tasks
  //------------------------------------------------------------------------
  task automatic check_word(input string what, input reg_word_t exp, input reg_word_t act);
    if (act !== exp) begin
      $display("Fail %s %s: expected %h, actual %h", test_name, what, exp, act);
      value_errs++;
    end
  endtask

  task automatic check_resp(input string what, input axi_resp_e exp, input axi_resp_e act);
    if (act !== exp) begin
      $display("Fail %s %s: expected %s, actual %b", test_name, what, exp.name(), act);
      value_errs++;
    end
  endtask

  task automatic check_vled(input string what, input vled_t exp, input vled_t act);
    if (act !== exp) begin
      $display("Fail %s %s: expected %h, actual %h", test_name, what, exp, act);
      value_errs++;
    end
  endtask

`endif

//--- testbench/tb_cl_hello_top.sv
//--------------------------------------------------------------------------
// Directed testbench for the hello-world AXI-Lite block
// Inputs change and outputs are sampled on the falling edge
// Random data comes from a fixed-seed xorshift so runs repeat exactly
//--------------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module tb_cl_hello_top;

  import cl_hello_pkg::*;

  localparam reg_word_t VERSION  = 32'hC0DE_0102;
  // Reset 2, byte swap 16, LED 8, unmapped 6, back-pressure 8
  localparam int        NUM_TXN  = 40;
  localparam int        HS_LIMIT = 20;

  logic      clk_main_a0;
  logic      rst_main_n_sync;
  logic      aw_valid;
  logic      aw_ready;
  axil_aw_t  aw;
  logic      w_valid;
  logic      w_ready;
  axil_w_t   w;
  logic      b_valid;
  logic      b_ready;
  axil_b_t   b;
  logic      ar_valid;
  logic      ar_ready;
  axil_ar_t  ar;
  logic      r_valid;
  logic      r_ready;
  axil_r_t   r;
  vled_t     vdip;
  vled_t     vled;

  int          value_errs;
  int          proto_errs;
  string       test_name;
  logic [31:0] rng_state;
  // Last word stored at HELLO_ADDR
  reg_word_t   last_hello;

  `include "tb_axil_tasks.svh"

  cl_hello_top #(.CL_VERSION(VERSION)) u_dut (.*);

  // 4 ns clock
  initial begin
    clk_main_a0 = 1'b0;
    forever #2 clk_main_a0 = ~clk_main_a0;
  end

  // Run limit from the transaction count
  initial begin
    repeat (NUM_TXN * 40) @(posedge clk_main_a0);
    $display("Watchdog expired in test %s, the run did not finish in time", test_name);
    $display("Simulation FAILED");
    $finish;
  end

  // Expected readback of the hello-world word
  function automatic reg_word_t byte_reverse(input reg_word_t x);
    reg_word_t y;
    for (int i = 0; i < 4; i++) begin
      y[8*i +: 8] = x[8*(3-i) +: 8];
    end
    return y;
  endfunction

  //------------------------------------------------------------------------
  // Directed tests
  //------------------------------------------------------------------------
  task automatic test_reset();
    reg_word_t data;
    axi_resp_e resp;
    test_name = "reset";
    check_vled("vled", 16'h0000, vled);
    axil_read(HELLO_ADDR, 0, data, resp);
    check_word("hello", 32'h0000_0000, data);
    check_resp("hello resp", RESP_OKAY, resp);
    axil_read(VERSION_ADDR, 0, data, resp);
    check_word("version", VERSION, data);
    check_resp("version resp", RESP_OKAY, resp);
  endtask

  // Write and read back with optional reordering and stalls
  task automatic write_read_hello(input int w_lead, input int b_hold, input int r_hold);
    reg_word_t word;
    reg_word_t data;
    axi_resp_e resp;
    word = next_rand();
    axil_write(HELLO_ADDR, word, w_lead, b_hold, resp);
    check_resp("write resp", RESP_OKAY, resp);
    axil_read(HELLO_ADDR, r_hold, data, resp);
    check_word("swapped", byte_reverse(word), data);
    check_resp("read resp", RESP_OKAY, resp);
    last_hello = word;
  endtask

  task automatic test_led_mask();
    reg_word_t   word;
    reg_word_t   data;
    axi_resp_e   resp;
    logic [31:0] dip_raw;
    test_name = "led_mask";
    repeat (4) begin
      word    = next_rand();
      dip_raw = next_rand();
      vdip    = dip_raw[15:0];
      axil_write(HELLO_ADDR, word, 0, 0, resp);
      check_resp("write resp", RESP_OKAY, resp);
      axil_read(VLED_ADDR, 0, data, resp);
      check_word("vled readback", {16'h0000, word[15:0]}, data);
      check_vled("vled port", word[15:0] & dip_raw[15:0], vled);
      last_hello = word;
    end
  endtask

  task automatic test_unmapped();
    reg_addr_t addrs [4] = '{32'h0000_0000, 32'h0000_050C, 32'h0000_04FC, 32'hFFFF_FFFC};
    reg_word_t data;
    axi_resp_e resp;
    test_name = "unmapped";
    foreach (addrs[i]) begin
      axil_read(addrs[i], 0, data, resp);
      check_word("marker", UNMAPPED_VALUE, data);
      check_resp("read resp", RESP_OKAY, resp);
    end
    axil_write(32'h0000_0510, next_rand(), 0, 0, resp);
    check_resp("write resp", RESP_OKAY, resp);
    axil_read(HELLO_ADDR, 0, data, resp);
    check_word("hello kept", byte_reverse(last_hello), data);
  endtask

  initial begin
    rst_main_n_sync = 1'b0;
    aw_valid        = 1'b0;
    aw              = '0;
    w_valid         = 1'b0;
    w               = '0;
    ar_valid        = 1'b0;
    ar              = '0;
    b_ready         = 1'b0;
    r_ready         = 1'b0;
    vdip            = 16'hFFFF;
    value_errs      = 0;
    proto_errs      = 0;
    test_name       = "startup";
    rng_state       = 32'd47988;
    last_hello      = '0;
    repeat (5) @(posedge clk_main_a0);
    @(negedge clk_main_a0);
    rst_main_n_sync = 1'b1;

    test_reset();
    test_name = "byte_swap";
    repeat (8) write_read_hello(0, 0, 0);
    test_led_mask();
    test_unmapped();
    // w leads aw by 2..5 cycles and responses stall for 0..7 cycles
    test_name = "backpressure";
    repeat (4) write_read_hello(2 + next_rand() % 4, next_rand() % 8, next_rand() % 8);

    $display("Errors: %0d value mismatches, %0d protocol errors", value_errs, proto_errs);
    if (value_errs == 0 && proto_errs == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
